// File: filelist.f
+incdir+verilog
verilog/scan_pkg.sv
verilog/char_class_decode.sv
verilog/regex_dfa.sv
verilog/stream_regex_unit.sv
verilog/scan_top.sv
test/scan_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scanner testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert \
      -f filelist.f \
      --top-module scan_tb \
      -o Vscan_tb; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vscan_tb > "$log" 2>&1; then
   cat "$log"
   echo "simulation exited with an error status"
   exit 1
fi

cat "$log"

if grep -q "Test failed" "$log"; then
   exit 1
fi

if ! grep -q "Test passed" "$log"; then
   echo "no pass line in $log"
   exit 1
fi

exit 0

// File: test/scan_tb.sv
`timescale 1ns/10ps

`include "scan_config.svh"

module scan_tb;

   // Run length bookkeeping for the watchdog
   localparam int num_random    = 200;
   localparam int max_payload   = 16;
   localparam int fixed_packets = 24;
   // Load, bytes, drain, eop and trailing idle cycles per packet
   localparam int packet_cycles = max_payload + `SCAN_DRAIN + 5;
   localparam int cycle_limit   = 10 + (fixed_packets + num_random) * packet_cycles + 200;

   logic                         clk;
   logic                         rst_n;
   logic [7:0]                   char_in;
   logic                         char_in_vld;
   logic                         load_state;
   logic [`SCAN_STREAM_ID_W-1:0] stream_id;
   logic                         new_stream_id;
   logic                         enable;
   logic                         eop;
   logic [`SCAN_COUNT_W-1:0]     count;
   logic                         fired;

   // Expected values, updated together with the eop drive
   logic                         exp_fired;
   logic [`SCAN_COUNT_W-1:0]     exp_count;

   // Reference model context, one entry per stream id
   scan_pkg::dfa_state_t model_state [0:`SCAN_STREAMS-1];
   logic                 used [0:`SCAN_STREAMS-1];
   logic [7:0]           payload [$];

   integer seed = 32'hdeb9_bcbd;
   int     errors;
   int     errors_at_start;
   int     pass_tests;
   int     fail_tests;
   int     cycles;

   scan_top dut0
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .load_state    (load_state),
      .stream_id     (stream_id),
      .new_stream_id (new_stream_id),
      .enable        (enable),
      .eop           (eop),
      .count         (count),
      .fired         (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Counter and flag come out of reset cleared
   a_reset_count : assert property (@(posedge clk) $rose(rst_n) |-> (count == '0))
      else
      begin
         errors++;
         $display("mismatch at %0t: count expected 0 actual %0d", $time, $sampled(count));
      end

   a_reset_fired : assert property (@(posedge clk) $rose(rst_n) |-> !fired)
      else
      begin
         errors++;
         $display("mismatch at %0t: fired expected 0 actual %0b", $time, $sampled(fired));
      end

   // Packet match flag as seen by eop
   a_fired_at_eop : assert property (
      @(posedge clk) disable iff (!rst_n)
      eop |-> (fired == exp_fired))
      else
      begin
         errors++;
         $display("mismatch at %0t: fired expected %0b actual %0b", $time,
                  $sampled(exp_fired), $sampled(fired));
      end

   // Counter one cycle after eop
   a_count_after_eop : assert property (
      @(posedge clk) disable iff (!rst_n)
      eop |=> (count == exp_count))
      else
      begin
         errors++;
         $display("mismatch at %0t: count expected %0d actual %0d", $time,
                  $sampled(exp_count), $sampled(count));
      end

   // Disabled stream drops its match right after eop
   a_clear_disabled : assert property (
      @(posedge clk) disable iff (!rst_n)
      (eop && !enable) |=> !fired)
      else
      begin
         errors++;
         $display("mismatch at %0t: fired expected 0 actual %0b", $time, $sampled(fired));
      end

   // New packet starts with the flag clear
   a_clear_on_load : assert property (
      @(posedge clk) disable iff (!rst_n)
      load_state |=> !fired)
      else
      begin
         errors++;
         $display("mismatch at %0t: fired expected 0 actual %0b", $time, $sampled(fired));
      end

   // Behavioral automaton on raw bytes
   function automatic scan_pkg::dfa_state_t model_step(input scan_pkg::dfa_state_t s,
                                                       input logic [7:0] c,
                                                       output logic acc);
      scan_pkg::dfa_state_t n;
      acc = 1'b0;
      n = scan_pkg::ST_IDLE;
      if (c == 8'h61)
         n = scan_pkg::ST_SAW_A;
      else if ((c >= 8'h30) && (c <= 8'h39))
      begin
         if ((s == scan_pkg::ST_SAW_A) || (s == scan_pkg::ST_DIGITS))
            n = scan_pkg::ST_DIGITS;
      end
      else if ((c == 8'h7a) && (s == scan_pkg::ST_DIGITS))
         acc = 1'b1;
      return n;
   endfunction

   function automatic logic is_pattern_char(input logic [7:0] c);
      return (c == 8'h61) || (c == 8'h7a) || ((c >= 8'h30) && (c <= 8'h39));
   endfunction

   // Filler byte that can never advance the pattern
   function automatic logic [7:0] pick_filler();
      logic [31:0] r;
      r = $random(seed);
      while (is_pattern_char(r[7:0]))
         r = $random(seed);
      return r[7:0];
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic set_text(input string s);
      payload.delete();
      for (int i = 0; i < s.len(); i++)
         payload.push_back(s[i]);
   endtask

   // One packet: load, bytes, drain, eop, then a spare cycle for the count check
   task automatic send_packet(input logic [`SCAN_STREAM_ID_W-1:0] id, input logic is_new,
                              input logic en);
      scan_pkg::dfa_state_t st;
      logic                 acc;
      logic                 matched;
      st = is_new ? scan_pkg::ST_IDLE : model_state[id];
      matched = 1'b0;
      foreach (payload[i])
      begin
         st = model_step(st, payload[i], acc);
         matched = matched | acc;
      end
      next_cycle();
      load_state    = 1'b1;
      stream_id     = id;
      new_stream_id = is_new;
      next_cycle();
      load_state = 1'b0;
      foreach (payload[i])
      begin
         char_in     = payload[i];
         char_in_vld = 1'b1;
         next_cycle();
      end
      char_in_vld = 1'b0;
      repeat (`SCAN_DRAIN) next_cycle();
      // Flag is still set at eop even for a disabled stream
      exp_fired = matched;
      if (en)
      begin
         if (matched)
            exp_count++;
         model_state[id] = st;
         // Only an enabled eop writes the context memory
         used[id] = 1'b1;
      end
      eop    = 1'b1;
      enable = en;
      next_cycle();
      eop = 1'b0;
      next_cycle();
   endtask

   task automatic text_packet(input logic [`SCAN_STREAM_ID_W-1:0] id, input logic is_new,
                              input logic en, input string s);
      set_text(s);
      send_packet(id, is_new, en);
   endtask

   task automatic finish_test(input string name);
      if (errors == errors_at_start)
         pass_tests++;
      else
         fail_tests++;
      $display("test %s done, %0d errors", name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   // Four streams, random lengths, enables and restore choices
   task automatic random_packets();
      logic [31:0]                  r;
      logic [31:0]                  rb;
      logic [3:0]                   d;
      logic [`SCAN_STREAM_ID_W-1:0] id;
      logic                         is_new;
      logic                         en;
      int                           len;
      for (int k = 0; k < num_random; k++)
      begin
         r = $random(seed);
         id = 6'd40 + {4'b0, r[1:0]};
         // First use of a stream must not read the unreset memory
         is_new = (r[4:2] == 3'd0) || !used[id];
         en = (r[6:5] != 2'd0);
         len = int'(r[11:8]);
         payload.delete();
         for (int j = 0; j < len; j++)
         begin
            rb = $random(seed);
            d = rb[6:3];
            if (d > 4'd9)
               d = d - 4'd6;
            case (rb[2:0])
               3'd0, 3'd1: payload.push_back(8'h61);
               3'd2, 3'd3: payload.push_back(8'h30 + {4'b0, d});
               3'd4:       payload.push_back(8'h7a);
               default:    payload.push_back(pick_filler());
            endcase
         end
         send_packet(id, is_new, en);
      end
   endtask

   // Watchdog
   initial
   begin
      cycles = 0;
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      char_in         = 8'h00;
      char_in_vld     = 1'b0;
      load_state      = 1'b0;
      stream_id       = '0;
      new_stream_id   = 1'b0;
      enable          = 1'b0;
      eop             = 1'b0;
      rst_n           = 1'b0;
      exp_fired       = 1'b0;
      exp_count       = '0;
      errors          = 0;
      errors_at_start = 0;
      pass_tests      = 0;
      fail_tests      = 0;
      for (int i = 0; i < `SCAN_STREAMS; i++)
      begin
         model_state[i] = scan_pkg::ST_IDLE;
         used[i]        = 1'b0;
      end
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      next_cycle();
      next_cycle();
      finish_test("reset");

      // Full pattern, then two near misses
      text_packet(6'd1, 1'b1, 1'b1, "xa123zq");
      text_packet(6'd2, 1'b1, 1'b1, "az");
      text_packet(6'd3, 1'b1, 1'b1, "a12y");
      finish_test("single_packet");

      // Pattern split over two packets, restored and then not
      text_packet(6'd4, 1'b1, 1'b1, "a45");
      text_packet(6'd4, 1'b0, 1'b1, "6z");
      text_packet(6'd5, 1'b1, 1'b1, "a45");
      text_packet(6'd5, 1'b1, 1'b1, "6z");
      finish_test("saved_context");

      // Two streams alternating with split patterns
      text_packet(6'd6, 1'b1, 1'b1, "a");
      text_packet(6'd7, 1'b1, 1'b1, "xa9");
      text_packet(6'd6, 1'b0, 1'b1, "12");
      text_packet(6'd7, 1'b0, 1'b1, "z");
      text_packet(6'd6, 1'b0, 1'b1, "3z");
      text_packet(6'd7, 1'b0, 1'b1, "a");
      text_packet(6'd6, 1'b0, 1'b1, "a");
      text_packet(6'd7, 1'b0, 1'b1, "4");
      text_packet(6'd6, 1'b0, 1'b1, "zz");
      text_packet(6'd7, 1'b0, 1'b1, "5z");
      finish_test("interleaved");

      // Disabled eop keeps the old context
      text_packet(6'd8, 1'b1, 1'b1, "a7");
      text_packet(6'd8, 1'b0, 1'b0, "z");
      text_packet(6'd8, 1'b0, 1'b1, "z");
      text_packet(6'd9, 1'b1, 1'b1, "a");
      text_packet(6'd9, 1'b0, 1'b0, "1");
      text_packet(6'd9, 1'b0, 1'b1, "z");
      finish_test("disabled_stream");

      random_packets();
      finish_test("random");

      $display("tests: %0d passed, %0d failed, %0d errors", pass_tests, fail_tests, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: verilog/char_class_decode.sv
`timescale 1ns/10ps

module char_class_decode
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [7:0]            char_in,
   input  logic                  char_in_vld,
   output scan_pkg::char_class_t char_class,
   output logic                  class_vld
);

   scan_pkg::char_class_t class_nxt;

   // Byte to class lookup
   // ASCII 'a' is 8'h61, 'z' is 8'h7a, digits are 8'h30 to 8'h39
   always_comb
   begin
      if (char_in == 8'h61)
         class_nxt = scan_pkg::CLS_A;
      else if (char_in == 8'h7a)
         class_nxt = scan_pkg::CLS_Z;
      else if ((char_in >= 8'h30) && (char_in <= 8'h39))
         class_nxt = scan_pkg::CLS_DIGIT;
      else
         class_nxt = scan_pkg::CLS_OTHER;
   end

   // Class register, only loaded on a strobed byte
   // Value is don't care while class_vld is low
   always_ff @(posedge clk)
   begin
      if (char_in_vld)
         char_class <= class_nxt;
   end

   // Strobe follows the class by one register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         class_vld <= 1'b0;
      else
         class_vld <= char_in_vld;
   end

endmodule

// File: verilog/regex_dfa.sv
`timescale 1ns/10ps

module regex_dfa
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  scan_pkg::char_class_t char_class,
   input  logic                  class_vld,
   input  scan_pkg::dfa_state_t  state_in,
   input  logic                  state_in_vld,
   output scan_pkg::dfa_state_t  state_out,
   output logic                  accept_out
);

   scan_pkg::dfa_state_t state_nxt;
   logic                 accept_nxt;

   // Transition function for a [0-9]+ z
   always_comb
   begin
      accept_nxt = 1'b0;
      case (char_class)
         // An 'a' always restarts the match, even mid pattern
         scan_pkg::CLS_A:
            state_nxt = scan_pkg::ST_SAW_A;
         // Digits only count after an 'a'
         scan_pkg::CLS_DIGIT:
            if ((state_out == scan_pkg::ST_SAW_A) || (state_out == scan_pkg::ST_DIGITS))
               state_nxt = scan_pkg::ST_DIGITS;
            else
               state_nxt = scan_pkg::ST_IDLE;
         // 'z' after digits completes the pattern
         scan_pkg::CLS_Z:
         begin
            if (state_out == scan_pkg::ST_DIGITS)
               accept_nxt = 1'b1;
            state_nxt = scan_pkg::ST_IDLE;
         end
         default:
            state_nxt = scan_pkg::ST_IDLE;
      endcase
   end

   // State register
   // A restore from the context memory wins over a byte step
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_out  <= scan_pkg::ST_IDLE;
         accept_out <= 1'b0;
      end
      else
      begin
         // Accept is a single cycle pulse
         accept_out <= 1'b0;
         if (state_in_vld)
            state_out <= state_in;
         else if (class_vld)
         begin
            state_out  <= state_nxt;
            accept_out <= accept_nxt;
         end
      end
   end

   // Restore lands before the first byte of a packet, so the two never meet
   a_no_restore_during_byte : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(state_in_vld && class_vld)
   );

   // Accept leaves ST_DIGITS, so a second accept right after is impossible
   a_accept_single_cycle : assert property (
      @(posedge clk) disable iff (!rst_n)
      accept_out |=> !accept_out
   );

endmodule

// File: verilog/scan_config.svh
`ifndef SCAN_CONFIG_SVH
`define SCAN_CONFIG_SVH

// Stream id width, one context entry per id
`define SCAN_STREAM_ID_W 6

// Depth of the per-stream context memory
`define SCAN_STREAMS 64

// Matched packet counter width, wraps on overflow
`define SCAN_COUNT_W 16

// Minimum idle cycles between last byte strobe and eop
// Covers the decode, automaton and flag registers
`define SCAN_DRAIN 2

`endif

// File: verilog/scan_pkg.sv
package scan_pkg;

   // Character classes produced by the decode stage
   // Only the bytes the pattern cares about get their own class
   typedef enum logic [1:0]
   {
      CLS_OTHER = 2'd0,
      CLS_A     = 2'd1,
      CLS_DIGIT = 2'd2,
      CLS_Z     = 2'd3
   } char_class_t;

   // Automaton states for the pattern a [0-9]+ z
   // ST_IDLE      nothing useful seen
   // ST_SAW_A     last byte was 'a'
   // ST_DIGITS    'a' then at least one digit
   // Accept is a transition out of ST_DIGITS, not a state of its own
   typedef enum logic [1:0]
   {
      ST_IDLE   = 2'd0,
      ST_SAW_A  = 2'd1,
      ST_DIGITS = 2'd2
   } dfa_state_t;

endpackage

// File: verilog/scan_top.sv
`timescale 1ns/10ps

`include "scan_config.svh"

module scan_top
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [7:0]                   char_in,
   input  logic                         char_in_vld,
   input  logic                         load_state,
   input  logic [`SCAN_STREAM_ID_W-1:0] stream_id,
   input  logic                         new_stream_id,
   input  logic                         enable,
   input  logic                         eop,
   output logic [`SCAN_COUNT_W-1:0]     count,
   output logic                         fired
);

   // Decoded byte stream into the stream unit
   scan_pkg::char_class_t char_class;
   logic                  class_vld;

   // Decode stage, bytes to two bit classes
   char_class_decode char_class_decode0
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .char_in     (char_in),
      .char_in_vld (char_in_vld),
      .char_class  (char_class),
      .class_vld   (class_vld)
   );

   // Automaton plus per-stream context and match counter
   stream_regex_unit stream_regex_unit0
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_class    (char_class),
      .class_vld     (class_vld),
      .eop           (eop),
      .load_state    (load_state),
      .enable        (enable),
      .new_stream_id (new_stream_id),
      .stream_id     (stream_id),
      .count         (count),
      .fired         (fired)
   );

endmodule

// File: verilog/stream_regex_unit.sv
`timescale 1ns/10ps

`include "scan_config.svh"

module stream_regex_unit
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  scan_pkg::char_class_t        char_class,
   input  logic                         class_vld,
   input  logic                         eop,
   input  logic                         load_state,
   input  logic                         enable,
   input  logic                         new_stream_id,
   input  logic [`SCAN_STREAM_ID_W-1:0] stream_id,
   output logic [`SCAN_COUNT_W-1:0]     count,
   output logic                         fired
);

   // Saved automaton state, one entry per stream id
   scan_pkg::dfa_state_t state_mem [0:`SCAN_STREAMS-1];

   scan_pkg::dfa_state_t state_in;
   logic                 state_in_vld;
   scan_pkg::dfa_state_t state_out;
   logic                 accept_out;

   // Speculative match flag for the packet in flight
   // Only committed to count at eop when the stream is enabled
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
         fired <= 1'b0;
      end
      else
      begin
         // New packet starts with no match
         if (load_state)
            fired <= 1'b0;

         // Any completed pattern in the packet marks it matched
         if (accept_out)
            fired <= 1'b1;

         if (eop)
         begin
            if (enable)
               count <= count + {{(`SCAN_COUNT_W-1){1'b0}}, fired};
            else
               // Disabled stream, drop the match
               fired <= 1'b0;
         end
      end
   end

   // Context save at eop, enabled streams only
   // A disabled stream keeps the state it had before this packet
   always_ff @(posedge clk)
   begin
      if (eop && enable)
         state_mem[stream_id] <= state_out;
   end

   // Restore path, presented to the automaton one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (load_state)
      begin
         // First packet of a stream starts clean
         if (new_stream_id)
            state_in <= scan_pkg::ST_IDLE;
         else
            state_in <= state_mem[stream_id];
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   regex_dfa regex_dfa0
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_class   (char_class),
      .class_vld    (class_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

   // Packet start and end are distinct pulses
   a_no_load_with_eop : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(load_state && eop)
   );

   // Last byte must reach the flag and the saved state before eop samples them
   a_eop_drain : assert property (
      @(posedge clk) disable iff (!rst_n)
      class_vld |-> !eop [*`SCAN_DRAIN]
   );

endmodule
